//--- Makefile
# Verilator flow for the multicast router stage

VERILATOR ?= verilator
TOP       := tb_floo_mcast_router
FILELIST  := sources.f
FLAGS     := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/floo_mcast_defines.svh
// Multicast router stage constants
// Coordinate and payload widths, direction bit indices in a route mask
// and communication type codes
`ifndef FLOO_MCAST_DEFINES_SVH
`define FLOO_MCAST_DEFINES_SVH

// Mesh coordinate widths
`define FLOO_XW 3
`define FLOO_YW 3

// Payload width of requests and responses
`define FLOO_DATA_W 32

// Router directions and their bit index in a route mask
`define FLOO_NUM_DIRS 5
`define FLOO_DIR_NORTH 0
`define FLOO_DIR_EAST 1
`define FLOO_DIR_SOUTH 2
`define FLOO_DIR_WEST 3
`define FLOO_DIR_EJECT 4

// Communication type codes carried in the header
`define FLOO_COMM_UNICAST 2'd0
`define FLOO_COMM_MULTICAST 2'd1
`define FLOO_COMM_COLLECTB 2'd2

`endif

//--- design/floo_mcast_fork.sv
// Multicast fork
// Holds one flit and hands a copy to each selected output, each with
// its own valid/ready; takes the next flit once the last copy leaves
`timescale 1ns/1ps
`include "floo_mcast_defines.svh"

module floo_mcast_fork (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  floo_mcast_pkg::flit_t       req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  floo_mcast_pkg::route_mask_t route_sel_i,
  output floo_mcast_pkg::flit_t       req_o,
  output floo_mcast_pkg::route_mask_t req_valid_o,
  input  floo_mcast_pkg::route_mask_t req_ready_i,
  output floo_mcast_pkg::flit_t       flit_q_o
);
  import floo_mcast_pkg::*;

  fork_state_e state_q;
  logic        first_q;
  route_mask_t pend_q;
  flit_t       flit_q;
  route_mask_t cur_mask;
  route_mask_t left_mask;
  logic        accept;

  // First busy cycle takes the mask straight from the mask unit
  always_comb begin
    cur_mask = '0;
    if (state_q == FORK_BUSY) begin
      cur_mask = first_q ? route_sel_i : pend_q;
    end
  end

  // Copies still owed after this cycle's transfers
  assign left_mask = cur_mask & ~req_ready_i;

  // Free when idle or when the last copies go out now
  assign req_ready_o = (state_q == FORK_IDLE) || (left_mask == '0);
  assign accept      = req_valid_i && req_ready_o;

  assign req_valid_o = cur_mask;
  assign req_o       = flit_q;
  assign flit_q_o    = flit_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FORK_IDLE;
      first_q <= 1'b0;
      pend_q  <= '0;
    end else if (accept) begin
      // Possibly in the same cycle as the last copy of the previous flit
      state_q <= FORK_BUSY;
      first_q <= 1'b1;
      pend_q  <= '0;
    end else if (state_q == FORK_BUSY) begin
      // Zero mask also lands here and drops the flit
      if (left_mask == '0) begin
        state_q <= FORK_IDLE;
      end
      first_q <= 1'b0;
      pend_q  <= left_mask;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      flit_q <= req_i;
    end
  end

  // Pending copies stay inside the mask of the held flit
  a_valid_in_mask: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == FORK_BUSY && !first_q) |-> ((req_valid_o & ~route_sel_i) == '0));

  // A waiting request keeps its valid and its flit until taken
  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_valid_i && !req_ready_o) |=> (req_valid_i && $stable(req_i)));

endmodule

//--- design/floo_mcast_pkg.sv
// Multicast router stage types
// Coordinates, flit header and payload, direction masks and FSM states
`include "floo_mcast_defines.svh"

package floo_mcast_pkg;

  // One mesh coordinate
  typedef logic [`FLOO_XW-1:0] coord_x_t;
  typedef logic [`FLOO_YW-1:0] coord_y_t;

  // Router or endpoint position
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } id_t;

  typedef logic [1:0] commtype_t;

  typedef logic [`FLOO_DATA_W-1:0] data_t;

  // Set bits of mask are don't-care positions of dst_id
  typedef struct packed {
    id_t       dst_id;
    id_t       src_id;
    id_t       mask;
    commtype_t commtype;
  } hdr_t;

  typedef struct packed {
    hdr_t  hdr;
    data_t payload;
  } flit_t;

  // One bit per router direction
  typedef logic [`FLOO_NUM_DIRS-1:0] route_mask_t;

  typedef enum logic {
    FORK_IDLE,
    FORK_BUSY
  } fork_state_e;

  typedef enum logic {
    JOIN_COLLECT,
    JOIN_SEND
  } join_state_e;

endpackage

//--- design/floo_mcast_router.sv
// Multicast router stage top
// Forward path replicates a request to the mesh outputs, backward path
// reduces the matching responses into one
`timescale 1ns/1ps
`include "floo_mcast_defines.svh"

module floo_mcast_router (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  floo_mcast_pkg::id_t                               xy_id_i,
  // Forward input
  input  floo_mcast_pkg::flit_t                             req_i,
  input  logic                                              req_valid_i,
  output logic                                              req_ready_o,
  // Forward outputs, one flit shared by all directions
  output floo_mcast_pkg::flit_t                             req_o,
  output floo_mcast_pkg::route_mask_t                       req_valid_o,
  input  floo_mcast_pkg::route_mask_t                       req_ready_i,
  // Backward inputs
  input  floo_mcast_pkg::flit_t [`FLOO_NUM_DIRS-1:0] rsp_i,
  input  floo_mcast_pkg::route_mask_t                       rsp_valid_i,
  output floo_mcast_pkg::route_mask_t                       rsp_ready_o,
  // Backward output
  output floo_mcast_pkg::flit_t                             rsp_o,
  output logic                                              rsp_valid_o,
  input  logic                                              rsp_ready_i
);
  import floo_mcast_pkg::*;

  flit_t       fork_flit;
  route_mask_t fwd_sel;
  flit_t       join_head;
  route_mask_t bwd_sel;

  // Output directions for the held request
  floo_route_xymask #(.FwdMode(1'b1)) u_fwd_mask (
    .channel_i   (fork_flit),
    .xy_id_i     (xy_id_i),
    .route_sel_o (fwd_sel)
  );

  floo_mcast_fork u_fork (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .route_sel_i (fwd_sel),
    .req_o       (req_o),
    .req_valid_o (req_valid_o),
    .req_ready_i (req_ready_i),
    .flit_q_o    (fork_flit)
  );

  // Input directions that return responses
  floo_route_xymask #(.FwdMode(1'b0)) u_bwd_mask (
    .channel_i   (join_head),
    .xy_id_i     (xy_id_i),
    .route_sel_o (bwd_sel)
  );

  floo_reduction_join u_join (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rsp_i       (rsp_i),
    .rsp_valid_i (rsp_valid_i),
    .rsp_ready_o (rsp_ready_o),
    .head_o      (join_head),
    .expect_i    (bwd_sel),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

//--- design/floo_reduction_join.sv
// Reduction join for multicast responses
// Waits until every expected input holds a response, pops them together,
// ORs their payloads and sends one merged response
`timescale 1ns/1ps
`include "floo_mcast_defines.svh"

module floo_reduction_join (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  floo_mcast_pkg::flit_t [`FLOO_NUM_DIRS-1:0] rsp_i,
  input  floo_mcast_pkg::route_mask_t                       rsp_valid_i,
  output floo_mcast_pkg::route_mask_t                       rsp_ready_o,
  output floo_mcast_pkg::flit_t                             head_o,
  input  floo_mcast_pkg::route_mask_t                       expect_i,
  output floo_mcast_pkg::flit_t                             rsp_o,
  output logic                                              rsp_valid_o,
  input  logic                                              rsp_ready_i
);
  import floo_mcast_pkg::*;

  join_state_e state_q;
  flit_t       rsp_q;
  flit_t       head;
  data_t       or_data;
  logic        fire;

  // Lowest-indexed valid input supplies the header
  always_comb begin
    head = rsp_i[0];
    for (int d = `FLOO_NUM_DIRS - 1; d >= 0; d--) begin
      if (rsp_valid_i[d]) begin
        head = rsp_i[d];
      end
    end
  end

  assign head_o = head;

  // Merge over the expected inputs only
  always_comb begin
    or_data = '0;
    for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
      if (expect_i[d]) begin
        or_data = or_data | rsp_i[d].payload;
      end
    end
  end

  // All expected responses present
  assign fire = (state_q == JOIN_COLLECT) && (expect_i != '0) &&
                ((expect_i & ~rsp_valid_i) == '0);

  // Pop the whole group at once, nothing while the result waits
  assign rsp_ready_o = fire ? expect_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= JOIN_COLLECT;
    end else begin
      case (state_q)
        JOIN_COLLECT: begin
          if (fire) begin
            state_q <= JOIN_SEND;
          end
        end
        JOIN_SEND: begin
          if (rsp_ready_i) begin
            state_q <= JOIN_COLLECT;
          end
        end
        default: state_q <= JOIN_COLLECT;
      endcase
    end
  end

  // Merged response register
  always_ff @(posedge clk_i) begin
    if (fire) begin
      rsp_q.hdr     <= head.hdr;
      rsp_q.payload <= or_data;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = (state_q == JOIN_SEND);

  // Responses not yet popped keep their valid while the group gathers
  a_rsp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    ((($past(rsp_valid_i) & ~$past(rsp_ready_o)) & ~rsp_valid_i) == '0));

endmodule

//--- design/floo_route_xymask.sv
// Multicast direction mask
// Forward mode names the outputs a flit is copied to (XY order),
// backward mode names the inputs that return responses (YX order)
`timescale 1ns/1ps
`include "floo_mcast_defines.svh"

module floo_route_xymask #(
  // 1 for forward output mask, 0 for backward input mask
  parameter bit FwdMode = 1'b1
) (
  input  floo_mcast_pkg::flit_t       channel_i,
  input  floo_mcast_pkg::id_t         xy_id_i,
  output floo_mcast_pkg::route_mask_t route_sel_o
);
  import floo_mcast_pkg::*;

  id_t         dst_id;
  id_t         src_id;
  id_t         mask_in;
  id_t         dst_max;
  id_t         dst_min;
  logic        x_match;
  logic        y_match;
  route_mask_t route_sel;

  // Backward path looks from the original destination side
  assign dst_id = FwdMode ? channel_i.hdr.dst_id : channel_i.hdr.src_id;
  assign src_id = FwdMode ? channel_i.hdr.src_id : channel_i.hdr.dst_id;

  // Only multicast flits spread on the forward path
  always_comb begin
    mask_in = channel_i.hdr.mask;
    if (FwdMode) begin
      case (channel_i.hdr.commtype)
        `FLOO_COMM_UNICAST:   mask_in = '0;
        `FLOO_COMM_MULTICAST: mask_in = channel_i.hdr.mask;
        `FLOO_COMM_COLLECTB:  mask_in = '0;
        default:              mask_in = channel_i.hdr.mask;
      endcase
    end
  end

  // Bounds of the destination set along each axis
  assign dst_max.x = dst_id.x | mask_in.x;
  assign dst_max.y = dst_id.y | mask_in.y;
  assign dst_min.x = dst_id.x & ~mask_in.x;
  assign dst_min.y = dst_id.y & ~mask_in.y;

  // This router lies in a destination column or row
  assign x_match = &(mask_in.x | ~(xy_id_i.x ^ dst_id.x));
  assign y_match = &(mask_in.y | ~(xy_id_i.y ^ dst_id.y));

  if (FwdMode) begin : gen_fwd
    always_comb begin
      route_sel = '0;
      route_sel[`FLOO_DIR_EJECT] = x_match && y_match;
      // X first, only along the source row
      if (xy_id_i.y == src_id.y) begin
        route_sel[`FLOO_DIR_EAST] = (xy_id_i.x >= src_id.x) && (xy_id_i.x < dst_max.x);
        route_sel[`FLOO_DIR_WEST] = (xy_id_i.x <= src_id.x) && (xy_id_i.x > dst_min.x);
      end
      // Then Y, within every destination column
      if (x_match) begin
        route_sel[`FLOO_DIR_NORTH] = (xy_id_i.y >= src_id.y) && (xy_id_i.y < dst_max.y);
        route_sel[`FLOO_DIR_SOUTH] = (xy_id_i.y <= src_id.y) && (xy_id_i.y > dst_min.y);
      end
    end
  end else begin : gen_bwd
    always_comb begin
      route_sel = '0;
      // Local endpoint answers if it was a receiver
      route_sel[`FLOO_DIR_EJECT] = x_match && y_match;
      // Y first, along the column of the original destination
      if (xy_id_i.x == src_id.x) begin
        route_sel[`FLOO_DIR_NORTH] = (xy_id_i.y >= src_id.y) && (xy_id_i.y < dst_max.y);
        route_sel[`FLOO_DIR_SOUTH] = (xy_id_i.y <= src_id.y) && (xy_id_i.y > dst_min.y);
      end
      // Then X, within every matching row
      if (y_match) begin
        route_sel[`FLOO_DIR_EAST] = (xy_id_i.x >= src_id.x) && (xy_id_i.x < dst_max.x);
        route_sel[`FLOO_DIR_WEST] = (xy_id_i.x <= src_id.x) && (xy_id_i.x > dst_min.x);
      end
    end
  end

  assign route_sel_o = route_sel;

endmodule

//--- dv/mcast_vectors.txt
# F xy_x xy_y dst_x dst_y src_x src_y mask_x mask_y comm payload(hex) exp(Ej W S E N)
# B xy_x xy_y dst_x dst_y src_x src_y mask_x mask_y comm p0 p1 p2 p3 p4 exp(Ej W S E N)
F 2 2 5 2 0 2 0 0 0 11110001 00010
F 2 2 2 5 2 2 0 0 0 22220002 00001
F 3 3 3 3 1 3 0 0 0 33330003 10000
F 2 2 0 0 2 2 7 7 1 44440004 11111
F 3 1 4 0 0 1 3 2 1 55550005 00010
F 5 1 4 0 0 1 3 2 1 66660006 00111
F 5 2 4 0 0 1 3 2 1 77770007 10000
F 2 2 4 2 2 2 7 7 2 88880008 00010
F 4 2 4 2 2 2 7 7 2 99990009 10000
F 4 3 0 3 4 3 3 0 1 aaaa000a 01000
F 2 2 5 5 0 0 0 0 0 bbbb000b 00000
F 1 4 1 0 1 4 0 3 1 cccc000c 00100
B 2 2 2 2 0 0 7 7 2 00000001 00000010 00000100 00001000 00010000 11111
B 2 2 2 2 4 2 0 0 2 f0000000 0f000000 00f00000 000f0000 0000f000 00010
B 3 3 1 3 3 3 0 0 2 12345678 9abcdef0 0badf00d 00c0ffee a5a5a5a5 10000
B 2 1 2 1 0 4 3 3 2 deadbeef 11111111 22222222 33333333 44444444 00001
B 1 4 2 4 0 4 3 3 2 01010101 02020202 04040404 80000001 10204080 11000
B 5 5 5 5 5 0 0 0 2 aaaa0000 bbbb0000 0000cccc 0000dddd eeee0000 00100

//--- dv/tb_clk_gen.sv
// Testbench clock source
// Free-running clock, starts low, 10 ns period
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime Period = 10.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period per toggle
  always begin
    #(Period / 2.0);
    clk_o = ~clk_o;
  end

endmodule

//--- dv/tb_floo_mcast_router.sv
// Testbench for the multicast router stage
// Reads forward and backward vectors, drives both paths with random
// back-pressure and arrival delays, and checks every copy and merged response
`timescale 1ns/1ps
`include "floo_mcast_defines.svh"

module tb_floo_mcast_router;
  import floo_mcast_pkg::*;

  localparam int ResetCycles = 8;
  localparam int CyclesPerVec = 64;

  // One line of the vector file
  typedef struct packed {
    logic                          is_fwd;
    id_t                           xy;
    hdr_t                          hdr;
    data_t [`FLOO_NUM_DIRS-1:0]    pay;
    route_mask_t                   exp;
  } vec_t;

  logic                        clk_i;
  logic                        rst_i;
  id_t                         xy_id_i;
  flit_t                       req_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  flit_t                       req_o;
  route_mask_t                 req_valid_o;
  route_mask_t                 req_ready_i;
  flit_t [`FLOO_NUM_DIRS-1:0]  rsp_i;
  route_mask_t                 rsp_valid_i;
  route_mask_t                 rsp_ready_o;
  flit_t                       rsp_o;
  logic                        rsp_valid_o;
  logic                        rsp_ready_i;

  vec_t        vecs[$];
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          error_count = 0;
  logic [15:0] lfsr_state;

  tb_clk_gen u_clk (
    .clk_o (clk_i)
  );

  floo_mcast_router dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .xy_id_i     (xy_id_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_o       (req_o),
    .req_valid_o (req_valid_o),
    .req_ready_i (req_ready_i),
    .rsp_i       (rsp_i),
    .rsp_valid_i (rsp_valid_i),
    .rsp_ready_o (rsp_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped at first failure");
  endtask

  // Watchdog against a stuck handshake
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  // 16-bit Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic check_flit(input string what, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input string what, input route_mask_t got,
                            input route_mask_t exp);
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    int          v[9];
    string       line;
    string       kind;
    data_t       p[5];
    route_mask_t e;
    vec_t        vec;
    fd = $fopen("dv/mcast_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file dv/mcast_vectors.txt");
      stop_on_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s", kind);
        vec = '0;
        if (kind == "F") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h %b", kind, v[0], v[1],
                      v[2], v[3], v[4], v[5], v[6], v[7], v[8], p[0], e);
          if (n != 12) begin
            $display("malformed forward line in vector file: %s", line);
            stop_on_failure();
          end
          vec.is_fwd = 1'b1;
          vec.pay[0] = p[0];
        end else if (kind == "B") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h %h %h %h %h %b", kind,
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                      p[0], p[1], p[2], p[3], p[4], e);
          if (n != 16) begin
            $display("malformed backward line in vector file: %s", line);
            stop_on_failure();
          end
          for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
            vec.pay[d] = p[d];
          end
        end else begin
          $display("unknown line kind in vector file: %s", line);
          stop_on_failure();
        end
        vec.xy.x         = coord_x_t'(v[0]);
        vec.xy.y         = coord_y_t'(v[1]);
        vec.hdr.dst_id.x = coord_x_t'(v[2]);
        vec.hdr.dst_id.y = coord_y_t'(v[3]);
        vec.hdr.src_id.x = coord_x_t'(v[4]);
        vec.hdr.src_id.y = coord_y_t'(v[5]);
        vec.hdr.mask.x   = coord_x_t'(v[6]);
        vec.hdr.mask.y   = coord_y_t'(v[7]);
        vec.hdr.commtype = commtype_t'(v[8]);
        vec.exp          = e;
        vecs.push_back(vec);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_out_ready(input bit backpressure);
    logic        b;
    route_mask_t r;
    r = '1;
    if (backpressure) begin
      for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
        next_bit(b);
        r[d] = b;
      end
    end
    req_ready_i = r;
  endtask

  // One forward flit, every expected copy exactly once
  task automatic run_fwd(input vec_t vec, input bit backpressure);
    flit_t       exp_flit;
    route_mask_t seen;
    route_mask_t xfer;
    route_mask_t left;
    logic        accepted;
    exp_flit.hdr     = vec.hdr;
    exp_flit.payload = vec.pay[0];
    @(posedge clk_i);
    #1;
    xy_id_i     = vec.xy;
    req_i       = exp_flit;
    req_valid_i = 1'b1;
    drive_out_ready(backpressure);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      check_mask("req_valid_o before accept", req_valid_o, '0);
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
    seen = '0;
    do begin
      drive_out_ready(backpressure);
      @(negedge clk_i);
      // Pending copies only, no repeats
      check_mask("req_valid_o", req_valid_o, vec.exp & ~seen);
      xfer = req_valid_o & req_ready_i;
      if (xfer != '0) begin
        check_flit("req_o", req_o, exp_flit);
      end
      seen = seen | xfer;
      left = vec.exp & ~seen;
      check_bit("req_ready_o", req_ready_o, left == '0);
      @(posedge clk_i);
      #1;
    end while (left != '0);
  endtask

  // Flits at one router taken on consecutive edges with all outputs free
  task automatic run_back_to_back();
    vec_t  sel[$];
    flit_t f;
    req_ready_i = '1;
    foreach (vecs[i]) begin
      if (vecs[i].is_fwd && vecs[i].exp != '0) begin
        if (sel.size() == 0 || vecs[i].xy == sel[0].xy) begin
          sel.push_back(vecs[i]);
        end
      end
    end
    @(posedge clk_i);
    #1;
    xy_id_i = sel[0].xy;
    for (int k = 0; k <= sel.size(); k++) begin
      if (k < sel.size()) begin
        f.hdr       = sel[k].hdr;
        f.payload   = sel[k].pay[0];
        req_i       = f;
        req_valid_i = 1'b1;
      end else begin
        req_valid_i = 1'b0;
      end
      @(negedge clk_i);
      if (k < sel.size()) begin
        check_bit("req_ready_o back-to-back", req_ready_o, 1'b1);
      end
      if (k > 0) begin
        f.hdr     = sel[k-1].hdr;
        f.payload = sel[k-1].pay[0];
        check_mask("req_valid_o back-to-back", req_valid_o, sel[k-1].exp);
        check_flit("req_o back-to-back", req_o, f);
      end else begin
        check_mask("req_valid_o before first flit", req_valid_o, '0);
      end
      @(posedge clk_i);
      #1;
    end
    @(negedge clk_i);
    check_mask("req_valid_o after burst", req_valid_o, '0);
  endtask

  // Responses on the expected inputs with random delays, one merged result
  task automatic run_bwd(input vec_t vec);
    flit_t exp_rsp;
    data_t merged;
    int    delay[5];
    int    t;
    logic  b;
    logic  popped;
    logic  done;
    logic  found;
    merged = '0;
    found = 1'b0;
    exp_rsp.hdr = vec.hdr;
    for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
      if (vec.exp[d]) begin
        merged = merged | vec.pay[d];
        // Header of the lowest expected input, recognized by its tag
        if (!found) begin
          exp_rsp.hdr.commtype = vec.hdr.commtype ^ commtype_t'(d);
          found = 1'b1;
        end
      end
      delay[d] = 0;
      for (int k = 0; k < 3; k++) begin
        next_bit(b);
        delay[d] = delay[d] * 2 + int'(b);
      end
    end
    exp_rsp.payload = merged;
    @(posedge clk_i);
    #1;
    xy_id_i = vec.xy;
    for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
      rsp_i[d].hdr          = vec.hdr;
      // Commtype does not steer the backward mask, so it tags the input
      rsp_i[d].hdr.commtype = vec.hdr.commtype ^ commtype_t'(d);
      rsp_i[d].payload      = vec.pay[d];
    end
    rsp_valid_i = '0;
    rsp_ready_i = 1'b0;
    t = 0;
    popped = 1'b0;
    while (!popped) begin
      for (int d = 0; d < `FLOO_NUM_DIRS; d++) begin
        if (vec.exp[d] && t >= delay[d]) begin
          rsp_valid_i[d] = 1'b1;
        end
      end
      @(negedge clk_i);
      check_bit("rsp_valid_o while collecting", rsp_valid_o, 1'b0);
      if ((vec.exp & ~rsp_valid_i) == '0) begin
        check_mask("rsp_ready_o at pop", rsp_ready_o, vec.exp);
        popped = 1'b1;
      end else begin
        check_mask("rsp_ready_o before all arrive", rsp_ready_o, '0);
      end
      @(posedge clk_i);
      #1;
      t++;
    end
    rsp_valid_i = '0;
    done = 1'b0;
    while (!done) begin
      next_bit(b);
      rsp_ready_i = b;
      @(negedge clk_i);
      check_mask("rsp_ready_o while result waits", rsp_ready_o, '0);
      // Result is up from the cycle after the pop until it is taken
      check_bit("rsp_valid_o while result waits", rsp_valid_o, 1'b1);
      check_flit("rsp_o", rsp_o, exp_rsp);
      done = rsp_ready_i;
      @(posedge clk_i);
      #1;
    end
    rsp_ready_i = 1'b0;
    @(negedge clk_i);
    check_bit("rsp_valid_o after transfer", rsp_valid_o, 1'b0);
  endtask

  initial begin
    rst_i       = 1'b1;
    xy_id_i     = '0;
    req_i       = '0;
    req_valid_i = 1'b0;
    req_ready_i = '0;
    rsp_i       = '0;
    rsp_valid_i = '0;
    rsp_ready_i = 1'b0;
    lfsr_state  = 16'd14845;
    load_vectors();
    cycle_limit = CyclesPerVec * vecs.size() + ResetCycles;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_bit("req_ready_o after reset", req_ready_o, 1'b1);
    check_mask("req_valid_o after reset", req_valid_o, '0);
    check_mask("rsp_ready_o after reset", rsp_ready_o, '0);
    check_bit("rsp_valid_o after reset", rsp_valid_o, 1'b0);
    // Forward with all outputs free, then with random stalls
    foreach (vecs[i]) begin
      if (vecs[i].is_fwd) begin
        run_fwd(vecs[i], 1'b0);
      end
    end
    foreach (vecs[i]) begin
      if (vecs[i].is_fwd) begin
        run_fwd(vecs[i], 1'b1);
      end
    end
    run_back_to_back();
    foreach (vecs[i]) begin
      if (!vecs[i].is_fwd) begin
        run_bwd(vecs[i]);
      end
    end
    if (error_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

endmodule

//--- sources.f
+incdir+design
design/floo_mcast_pkg.sv
design/floo_route_xymask.sv
design/floo_mcast_fork.sv
design/floo_reduction_join.sv
design/floo_mcast_router.sv
dv/tb_clk_gen.sv
dv/tb_floo_mcast_router.sv
